// File: fp_alu_pkg.sv
/* Shared widths, operation codes and pipeline stage records of the multi-cycle ALU.
   Every block of the unit refers to these by scoped name. */
package fp_alu_pkg;

	localparam int WORD_WIDTH = 32;	// Operand and result word
	localparam int EXP_WIDTH = 8;	// Single precision exponent
	localparam int SIG_WIDTH = 23;	// Stored fraction, hidden bit excluded

	// Operation codes issued by the execute stage
	typedef enum logic [3:0] {
		OP_NONE = 4'd0,
		OP_IMUL = 4'd1,
		OP_FMUL = 4'd2,
		OP_FADD = 4'd3,
		OP_FSUB = 4'd4,
		OP_FGTR = 4'd5,
		OP_FLT  = 4'd6,
		OP_FGTE = 4'd7,
		OP_FLTE = 4'd8
	} op_e;

	typedef struct packed {
		logic                  valid;
		op_e                   op;
		logic [WORD_WIDTH-1:0] operand1;
		logic [WORD_WIDTH-1:0] operand2;
	} alu_issue_t;

	// Adder stage 1, significands carry hidden bit and two guard bits
	typedef struct packed {
		logic                 valid;
		op_e                  op;
		logic [EXP_WIDTH-1:0] exponent;	// Larger of the two
		logic [SIG_WIDTH+2:0] sig1;
		logic [SIG_WIDTH+2:0] sig2;
		logic [5:0]           shift;	// Alignment distance, saturated
		logic                 swap;	// Operand 2 has the larger magnitude
		logic                 subtract;	// Effective signs differ
		logic                 sign;	// Sign of the larger operand
		logic                 is_inf;
		logic                 is_nan;
	} add_align_t;

	typedef struct packed {
		logic                 sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [SIG_WIDTH+3:0] sum;	// Carry bit on top
		logic                 is_inf;
		logic                 is_nan;
		logic                 is_zero;
	} add_sum_t;

	// Value is significand / 2^46 * 2^exponent before normalizing
	typedef struct packed {
		logic                        sign;
		logic signed [EXP_WIDTH+1:0] exponent;	// Room for mul over/underflow
		logic [2*SIG_WIDTH+1:0]      significand;
		logic                        is_inf;
		logic                        is_nan;
		logic                        is_zero;
	} norm_in_t;

	typedef struct packed {
		logic                 sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [SIG_WIDTH-1:0] fraction;
		logic                 is_inf;
		logic                 is_nan;
		logic                 is_zero;
	} norm_out_t;

endpackage

// File: fp_add_align.sv
/* First floating-point adder stage. Unpacks both operands, orders them by magnitude
   and registers the alignment shift and the inf/nan outcome for the next stage. */
`timescale 1ns/1ps

module fp_add_align (
	input  logic                   clk,
	input  logic                   reset,
	input  fp_alu_pkg::alu_issue_t issue_i,
	output fp_alu_pkg::add_align_t align_o
);

	localparam int EW = fp_alu_pkg::EXP_WIDTH;
	localparam int SW = fp_alu_pkg::SIG_WIDTH;
	localparam int WW = fp_alu_pkg::WORD_WIDTH;
	localparam logic [EW-1:0] EXP_ONES = '1;
	localparam int SHIFT_SAT = SW + 3;	// Past this everything is shifted out

	logic [EW-1:0] exp1;
	logic [EW-1:0] exp2;
	logic [EW-1:0] exp_large;
	logic [EW-1:0] exp_diff;
	logic [SW-1:0] frac1;
	logic [SW-1:0] frac2;
	logic [SW+2:0] sig1;
	logic [SW+2:0] sig2;
	logic          sign1;
	logic          sign2_eff;
	logic          negate2;
	logic          swap;
	logic          inf1;
	logic          inf2;
	logic          nan1;
	logic          nan2;
	logic          res_nan;
	logic          res_inf;

	// Subtract and every compare work on operand1 - operand2
	assign negate2 = issue_i.op inside {fp_alu_pkg::OP_FSUB, fp_alu_pkg::OP_FGTR,
		fp_alu_pkg::OP_FLT, fp_alu_pkg::OP_FGTE, fp_alu_pkg::OP_FLTE};

	assign sign1 = issue_i.operand1[WW-1];
	assign sign2_eff = issue_i.operand2[WW-1] ^ negate2;
	assign exp1 = issue_i.operand1[WW-2 -: EW];
	assign exp2 = issue_i.operand2[WW-2 -: EW];
	assign frac1 = issue_i.operand1[SW-1:0];
	assign frac2 = issue_i.operand2[SW-1:0];

	// Zero exponent flushes to zero, hidden bit plus two guard bits otherwise
	assign sig1 = (exp1 == '0) ? '0 : {1'b1, frac1, 2'b00};
	assign sig2 = (exp2 == '0) ? '0 : {1'b1, frac2, 2'b00};

	assign swap = issue_i.operand2[WW-2:0] > issue_i.operand1[WW-2:0];	// Exp and frac together
	assign exp_large = swap ? exp2 : exp1;
	assign exp_diff = swap ? exp2 - exp1 : exp1 - exp2;

	assign inf1 = exp1 == EXP_ONES && frac1 == '0;
	assign inf2 = exp2 == EXP_ONES && frac2 == '0;
	assign nan1 = exp1 == EXP_ONES && frac1 != '0;
	assign nan2 = exp2 == EXP_ONES && frac2 != '0;
	assign res_nan = nan1 || nan2 || (inf1 && inf2 && (sign1 ^ sign2_eff));	// inf - inf
	assign res_inf = (inf1 || inf2) && !res_nan;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			align_o <= '0;
		else
		begin
			align_o.valid <= issue_i.valid;
			align_o.op <= issue_i.op;
			align_o.exponent <= exp_large;
			align_o.sig1 <= sig1;
			align_o.sig2 <= sig2;
			align_o.shift <= (exp_diff > EW'(SHIFT_SAT)) ? 6'(SHIFT_SAT) : exp_diff[5:0];
			align_o.swap <= swap;
			align_o.subtract <= sign1 ^ sign2_eff;
			align_o.sign <= swap ? sign2_eff : sign1;	// Larger magnitude wins
			align_o.is_inf <= res_inf;
			align_o.is_nan <= res_nan;
		end
	end

endmodule

// File: fp_add_sum.sv
/* Second and third floating-point adder stages. Aligns the smaller significand, then
   adds or subtracts magnitudes; the registered sum feeds the shared normalizer. */
`timescale 1ns/1ps

module fp_add_sum (
	input  logic                   clk,
	input  logic                   reset,
	input  fp_alu_pkg::add_align_t align_i,
	output fp_alu_pkg::add_sum_t   sum_o
);

	localparam int EW = fp_alu_pkg::EXP_WIDTH;
	localparam int SW = fp_alu_pkg::SIG_WIDTH;

	logic          load_s2;
	logic          valid_s2;
	logic [EW-1:0] exp_s2;
	logic          sign_s2;
	logic          sub_s2;
	logic          inf_s2;
	logic          nan_s2;
	logic [SW+2:0] large_s2;	// Larger magnitude, unshifted
	logic [SW+2:0] small_s2;	// Aligned to the larger exponent
	logic [SW+3:0] sum_next;
	logic          diff_zero;

	// Only adder-path ops load, multiplies leave these stages idle
	assign load_s2 = align_i.valid && !(align_i.op inside {fp_alu_pkg::OP_NONE,
		fp_alu_pkg::OP_IMUL, fp_alu_pkg::OP_FMUL});

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_s2 <= 1'b0;
			exp_s2 <= '0;
			sign_s2 <= 1'b0;
			sub_s2 <= 1'b0;
			inf_s2 <= 1'b0;
			nan_s2 <= 1'b0;
			large_s2 <= '0;
			small_s2 <= '0;
		end
		else
		begin
			valid_s2 <= load_s2;
			if (load_s2)
			begin
				exp_s2 <= align_i.exponent;
				sign_s2 <= align_i.sign;
				sub_s2 <= align_i.subtract;
				inf_s2 <= align_i.is_inf;
				nan_s2 <= align_i.is_nan;
				large_s2 <= align_i.swap ? align_i.sig2 : align_i.sig1;
				// Guard bits catch what falls off the bottom
				small_s2 <= (align_i.swap ? align_i.sig1 : align_i.sig2) >> align_i.shift;
			end
		end
	end

	// Ordered by magnitude, so the difference never goes negative
	assign sum_next = sub_s2 ? {1'b0, large_s2} - {1'b0, small_s2}
		: {1'b0, large_s2} + {1'b0, small_s2};
	assign diff_zero = sum_next == '0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			sum_o <= '0;
		else if (valid_s2)
		begin
			sum_o.sum <= sum_next;
			sum_o.exponent <= exp_s2;
			sum_o.sign <= (sub_s2 && diff_zero) ? 1'b0 : sign_s2;	// x - x is +0
			sum_o.is_inf <= inf_s2;
			sum_o.is_nan <= nan_s2;
			sum_o.is_zero <= diff_zero && !inf_s2 && !nan_s2;
		end
	end

endmodule

// File: fp_mul_prepare.sv
/* Combinational front end of the multiply path. Feeds the integer multiplier with raw
   words for IMUL or hidden-bit significands for FMUL, plus exponent, sign and flags. */
`timescale 1ns/1ps

module fp_mul_prepare (
	input  fp_alu_pkg::alu_issue_t                      issue_i,
	output logic [fp_alu_pkg::WORD_WIDTH-1:0]           multiplicand_o,
	output logic [fp_alu_pkg::WORD_WIDTH-1:0]           multiplier_o,
	output logic signed [fp_alu_pkg::EXP_WIDTH+1:0]     exponent_o,
	output logic                                        sign_o,
	output logic                                        is_inf_o,
	output logic                                        is_nan_o,
	output logic                                        is_zero_o
);

	localparam int EW = fp_alu_pkg::EXP_WIDTH;
	localparam int SW = fp_alu_pkg::SIG_WIDTH;
	localparam int WW = fp_alu_pkg::WORD_WIDTH;
	localparam int PAD = WW - SW - 1;	// Zero bits above the 24-bit significand
	localparam logic [EW-1:0] EXP_ONES = '1;
	localparam logic signed [EW+1:0] EXP_BIAS = (1 << (EW - 1)) - 1;

	logic [EW-1:0] exp1;
	logic [EW-1:0] exp2;
	logic [SW-1:0] frac1;
	logic [SW-1:0] frac2;
	logic          zero1;
	logic          zero2;
	logic          inf1;
	logic          inf2;
	logic          nan1;
	logic          nan2;

	assign exp1 = issue_i.operand1[WW-2 -: EW];
	assign exp2 = issue_i.operand2[WW-2 -: EW];
	assign frac1 = issue_i.operand1[SW-1:0];
	assign frac2 = issue_i.operand2[SW-1:0];
	assign zero1 = exp1 == '0;	// Denormals count as zero
	assign zero2 = exp2 == '0;
	assign inf1 = exp1 == EXP_ONES && frac1 == '0;
	assign inf2 = exp2 == EXP_ONES && frac2 == '0;
	assign nan1 = exp1 == EXP_ONES && frac1 != '0;
	assign nan2 = exp2 == EXP_ONES && frac2 != '0;

	always_comb
	begin
		if (issue_i.op == fp_alu_pkg::OP_IMUL)
		begin
			multiplicand_o = issue_i.operand1;
			multiplier_o = issue_i.operand2;
		end
		else
		begin
			multiplicand_o = zero1 ? '0 : {{PAD{1'b0}}, 1'b1, frac1};
			multiplier_o = zero2 ? '0 : {{PAD{1'b0}}, 1'b1, frac2};
		end
	end

	// Bias counted twice in the sum, take one out
	assign exponent_o = $signed({2'b00, exp1}) + $signed({2'b00, exp2}) - EXP_BIAS;
	assign sign_o = issue_i.operand1[WW-1] ^ issue_i.operand2[WW-1];
	assign is_nan_o = nan1 || nan2 || (inf1 && zero2) || (inf2 && zero1);
	assign is_inf_o = (inf1 || inf2) && !is_nan_o;
	assign is_zero_o = (zero1 || zero2) && !is_nan_o && !is_inf_o;

endmodule

// File: integer_multiplier.sv
/* Three-stage pipelined unsigned multiplier, used for IMUL and FMUL significands.
   Stage 1 forms half-word partial products, stages 2 and 3 sum them. */
`timescale 1ns/1ps

module integer_multiplier (
	input  logic                                clk,
	input  logic                                reset,
	input  logic [fp_alu_pkg::WORD_WIDTH-1:0]   multiplicand_i,
	input  logic [fp_alu_pkg::WORD_WIDTH-1:0]   multiplier_i,
	output logic [2*fp_alu_pkg::WORD_WIDTH-1:0] product_o
);

	localparam int HW = fp_alu_pkg::WORD_WIDTH / 2;

	logic [2*HW-1:0] pp_ll;	// Stage 1 partial products
	logic [2*HW-1:0] pp_lh;
	logic [2*HW-1:0] pp_hl;
	logic [2*HW-1:0] pp_hh;
	logic [2*HW:0]   mid_q;	// Stage 2, cross terms with carry
	logic [4*HW-1:0] outer_q;	// Stage 2, {hh, ll} side by side

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pp_ll <= '0;
			pp_lh <= '0;
			pp_hl <= '0;
			pp_hh <= '0;
			mid_q <= '0;
			outer_q <= '0;
			product_o <= '0;
		end
		else
		begin
			pp_ll <= multiplicand_i[HW-1:0] * multiplier_i[HW-1:0];
			pp_lh <= multiplicand_i[HW-1:0] * multiplier_i[2*HW-1:HW];
			pp_hl <= multiplicand_i[2*HW-1:HW] * multiplier_i[HW-1:0];
			pp_hh <= multiplicand_i[2*HW-1:HW] * multiplier_i[2*HW-1:HW];
			mid_q <= {1'b0, pp_lh} + {1'b0, pp_hl};
			outer_q <= {pp_hh, pp_ll};
			product_o <= outer_q + {{(HW-1){1'b0}}, mid_q, {HW{1'b0}}};	// Cross terms at bit 16
		end
	end

endmodule

// File: fp_normalize.sv
/* Shared combinational normalizer for the adder and multiplier paths. Moves the leading
   one into the hidden position, adjusts the exponent and saturates to inf or zero. */
`timescale 1ns/1ps

module fp_normalize (
	input  fp_alu_pkg::norm_in_t  norm_i,
	output fp_alu_pkg::norm_out_t norm_o
);

	localparam int EW = fp_alu_pkg::EXP_WIDTH;
	localparam int SW = fp_alu_pkg::SIG_WIDTH;
	localparam int SIG_IN = 2 * (SW + 1);	// 48-bit raw significand
	localparam int EXP_MAX = (1 << EW) - 1;	// All ones means inf
	localparam logic signed [EW+2:0] EXP_BUMP = 1;	// Unit position sits one below the top

	logic [5:0]             lead_pos;
	logic [5:0]             lead_zeros;
	logic [SIG_IN-1:0]      sig_shifted;
	logic signed [EW+2:0]   exp_adj;
	logic                   sig_zero;
	logic                   overflow;
	logic                   underflow;
	logic                   out_zero;
	logic                   out_inf;

	// Leading one search, highest set bit wins
	always_comb
	begin
		lead_pos = '0;
		for (int i = 0; i < SIG_IN; i++)
		begin
			if (norm_i.significand[i])
				lead_pos = 6'(i);
		end
	end

	assign sig_zero = norm_i.significand == '0;
	assign lead_zeros = 6'(SIG_IN - 1) - lead_pos;
	assign sig_shifted = norm_i.significand << lead_zeros;	// Leading one now at the top

	assign exp_adj = norm_i.exponent + EXP_BUMP - $signed({{(EW-3){1'b0}}, lead_zeros});
	assign overflow = exp_adj >= EXP_MAX;
	assign underflow = exp_adj <= 0;	// Flushed, no denormals

	assign out_inf = !norm_i.is_nan && (norm_i.is_inf || (overflow && !sig_zero));
	assign out_zero = !norm_i.is_nan && !norm_i.is_inf
		&& (norm_i.is_zero || sig_zero || underflow);

	always_comb
	begin
		norm_o.sign = norm_i.sign;	// Kept on underflow too
		norm_o.is_nan = norm_i.is_nan;
		norm_o.is_inf = out_inf;
		norm_o.is_zero = out_zero;
		if (out_zero)
		begin
			norm_o.exponent = '0;
			norm_o.fraction = '0;
		end
		else
		begin
			norm_o.exponent = exp_adj[EW-1:0];
			norm_o.fraction = sig_shifted[SIG_IN-2 -: SW];	// Hidden bit dropped, truncated
		end
	end

endmodule

// File: multi_cycle_alu.sv
/* Multi-cycle arithmetic unit of the execute stage: IMUL, FMUL, FADD, FSUB and compares.
   Fixed three-edge latency, one issue per cycle, result assembled combinationally. */
`timescale 1ns/1ps

module multi_cycle_alu (
	input  logic                              clk,
	input  logic                              reset,
	input  fp_alu_pkg::alu_issue_t            issue_i,
	output logic                              result_valid_o,
	output logic [fp_alu_pkg::WORD_WIDTH-1:0] result_o
);

	localparam int WW = fp_alu_pkg::WORD_WIDTH;
	localparam int EW = fp_alu_pkg::EXP_WIDTH;
	localparam int SW = fp_alu_pkg::SIG_WIDTH;
	localparam int SUM_PAD = 2 * (SW + 1) - (SW + 4);	// Lines the sum up with the product

	// Multiply side data riding alongside the multiplier pipeline
	typedef struct packed {
		logic signed [EW+1:0] exponent;
		logic                 sign;
		logic                 is_inf;
		logic                 is_nan;
		logic                 is_zero;
	} mul_side_t;

	fp_alu_pkg::add_align_t add_align;
	fp_alu_pkg::add_sum_t   add_sum;
	fp_alu_pkg::norm_in_t   norm_in;
	fp_alu_pkg::norm_out_t  norm_out;
	fp_alu_pkg::op_e        op_q [0:2];	// Op delay line, stage 3 at the end
	logic [2:0]             valid_q;
	mul_side_t              mul_side;
	mul_side_t              mul_q [0:2];
	logic [WW-1:0]          multiplicand;
	logic [WW-1:0]          multiplier;
	logic [2*WW-1:0]        product;
	logic                   diff_zero;
	logic                   diff_neg;
	logic                   cmp_bit;

	fp_add_align u_fp_add_align (
		.clk     (clk),
		.reset   (reset),
		.issue_i (issue_i),
		.align_o (add_align)
	);

	fp_add_sum u_fp_add_sum (
		.clk     (clk),
		.reset   (reset),
		.align_i (add_align),
		.sum_o   (add_sum)
	);

	fp_mul_prepare u_fp_mul_prepare (
		.issue_i        (issue_i),
		.multiplicand_o (multiplicand),
		.multiplier_o   (multiplier),
		.exponent_o     (mul_side.exponent),
		.sign_o         (mul_side.sign),
		.is_inf_o       (mul_side.is_inf),
		.is_nan_o       (mul_side.is_nan),
		.is_zero_o      (mul_side.is_zero)
	);

	integer_multiplier u_integer_multiplier (
		.clk            (clk),
		.reset          (reset),
		.multiplicand_i (multiplicand),
		.multiplier_i   (multiplier),
		.product_o      (product)
	);

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			valid_q <= '0;
			for (int i = 0; i < 3; i++)
			begin
				op_q[i] <= fp_alu_pkg::OP_NONE;
				mul_q[i] <= '0;
			end
		end
		else
		begin
			valid_q <= {valid_q[1:0], issue_i.valid};
			op_q[0] <= issue_i.valid ? issue_i.op : fp_alu_pkg::OP_NONE;	// Bubbles become NONE
			op_q[1] <= op_q[0];
			op_q[2] <= op_q[1];
			mul_q[0] <= mul_side;
			mul_q[1] <= mul_q[0];
			mul_q[2] <= mul_q[1];
		end
	end

	// Normalizer source picked by the stage-3 op
	always_comb
	begin
		if (op_q[2] == fp_alu_pkg::OP_FMUL)
		begin
			norm_in.sign = mul_q[2].sign;
			norm_in.exponent = mul_q[2].exponent;
			norm_in.significand = product[2*SW+1:0];	// 24 x 24 fits in 48
			norm_in.is_inf = mul_q[2].is_inf;
			norm_in.is_nan = mul_q[2].is_nan;
			norm_in.is_zero = mul_q[2].is_zero;
		end
		else
		begin
			norm_in.sign = add_sum.sign;
			norm_in.exponent = {2'b00, add_sum.exponent};
			norm_in.significand = {add_sum.sum, {SUM_PAD{1'b0}}};
			norm_in.is_inf = add_sum.is_inf;
			norm_in.is_nan = add_sum.is_nan;
			norm_in.is_zero = add_sum.is_zero;
		end
	end

	fp_normalize u_fp_normalize (
		.norm_i (norm_in),
		.norm_o (norm_out)
	);

	// Compares read the sign and zeroness of operand1 - operand2
	assign diff_zero = norm_out.is_zero;
	assign diff_neg = norm_out.sign && !norm_out.is_zero;

	always_comb
	begin
		case (op_q[2])
			fp_alu_pkg::OP_FGTR: cmp_bit = !diff_zero && !diff_neg;
			fp_alu_pkg::OP_FLT:  cmp_bit = diff_neg;
			fp_alu_pkg::OP_FGTE: cmp_bit = !diff_neg;
			fp_alu_pkg::OP_FLTE: cmp_bit = diff_zero || diff_neg;
			default:             cmp_bit = 1'b0;
		endcase
	end

	always_comb
	begin
		case (op_q[2])
			fp_alu_pkg::OP_IMUL:
				result_o = product[WW-1:0];	// Low half only
			fp_alu_pkg::OP_FGTR, fp_alu_pkg::OP_FLT, fp_alu_pkg::OP_FGTE, fp_alu_pkg::OP_FLTE:
				result_o = {{(WW-1){1'b0}}, cmp_bit};
			default:
			begin
				if (norm_out.is_nan)
					result_o = {norm_out.sign, {EW{1'b1}}, {SW{1'b1}}};	// Canonical nan
				else if (norm_out.is_inf)
					result_o = {norm_out.sign, {EW{1'b1}}, {SW{1'b0}}};
				else
					result_o = {norm_out.sign, norm_out.exponent, norm_out.fraction};
			end
		endcase
	end

	assign result_valid_o = valid_q[2];

endmodule

// File: tb_multi_cycle_alu.sv
/* Self-checking testbench for the multi-cycle ALU. Drives IMUL, float arithmetic,
   compares and special values, and checks every result against a reference model. */
`timescale 1ns/1ps

module tb_multi_cycle_alu;

	localparam int N_GAP = 6;	// Ones in GAP_PATTERN
	localparam int N_IMUL = 40;
	localparam int N_ARITH = 64;	// 60 random plus 4 equal FSUB
	localparam int N_CMP = 68;	// 60 random plus 8 equal pairs
	localparam int N_SPECIAL = 10;
	localparam int N_MIX = 150;
	localparam int TOTAL_OPS = N_GAP + N_IMUL + N_ARITH + N_CMP + N_SPECIAL + N_MIX;
	localparam int CYCLE_LIMIT = 20 * TOTAL_OPS + 100;
	localparam logic [9:0] GAP_PATTERN = 10'b1101100101;	// LSB issued first
	localparam logic [31:0] F_INF = 32'h7f800000;
	localparam logic [31:0] F_NAN_IN = 32'h7fc00000;
	localparam logic [31:0] F_NAN = 32'h7fffffff;	// Sign is not checked for nan

	logic                   clk = 1'b0;
	logic                   reset;
	fp_alu_pkg::alu_issue_t issue_i;
	logic                   result_valid_o;
	logic [31:0]            result_o;
	logic [31:0]            lcg_state = 32'd70;
	logic [31:0]            expect_q [$];	// Expected results in issue order
	logic [31:0]            expect_word;
	logic                   nan_match;
	int                     checks_passed = 0;
	int                     checks_failed = 0;
	int                     fails_at_start = 0;
	int                     valid_run = 0;
	int                     longest_run = 0;
	int                     cycle_count = 0;

	always #2 clk = ~clk;	// 4 ns period

	multi_cycle_alu u_multi_cycle_alu (
		.clk            (clk),
		.reset          (reset),
		.issue_i        (issue_i),
		.result_valid_o (result_valid_o),
		.result_o       (result_o)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Signed integer in -255..255
	function automatic int small_random();
		logic [31:0] r;
		int          mag;
		r = next_random();
		mag = int'(r[23:16]);
		return r[30] ? -mag : mag;
	endfunction

	// Exact for magnitudes below 2^24, zero always positive
	function automatic logic [31:0] to_float(input int value);
		int          mag;
		int          msb;
		logic [31:0] word;
		if (value == 0)
			return '0;
		mag = (value < 0) ? -value : value;
		msb = 0;
		for (int i = 0; i < 24; i++)
		begin
			if (mag[i])
				msb = i;
		end
		word[31] = value < 0;
		word[30:23] = 8'(127 + msb);
		word[22:0] = 23'(mag << (23 - msb));	// Hidden bit falls off
		return word;
	endfunction

	function automatic logic [31:0] float_expect(input fp_alu_pkg::op_e op, input int a,
		input int b);
		case (op)
			fp_alu_pkg::OP_FMUL:
				return (a * b == 0) ? {(a < 0) ^ (b < 0), 31'b0} : to_float(a * b);
			fp_alu_pkg::OP_FADD: return to_float(a + b);
			fp_alu_pkg::OP_FSUB: return to_float(a - b);	// x - x gives +0
			fp_alu_pkg::OP_FGTR: return 32'(a - b > 0);
			fp_alu_pkg::OP_FLT:  return 32'(a - b < 0);
			fp_alu_pkg::OP_FGTE: return 32'(a - b >= 0);
			fp_alu_pkg::OP_FLTE: return 32'(a - b <= 0);
			default:             return '0;
		endcase
	endfunction

	task automatic issue_op(input fp_alu_pkg::op_e op, input logic [31:0] a,
		input logic [31:0] b, input logic [31:0] expected);
		@(posedge clk);
		issue_i.valid <= 1'b1;
		issue_i.op <= op;
		issue_i.operand1 <= a;
		issue_i.operand2 <= b;
		expect_q.push_back(expected);
	endtask

	task automatic issue_float(input fp_alu_pkg::op_e op, input int a, input int b);
		issue_op(op, to_float(a), to_float(b), float_expect(op, a, b));
	endtask

	task automatic issue_imul();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] low;
		a = next_random();
		b = next_random();
		low = a * b;	// Low word of the product
		issue_op(fp_alu_pkg::OP_IMUL, a, b, low);
	endtask

	task automatic idle_cycles(input int count);
		repeat (count)
		begin
			@(posedge clk);
			issue_i <= '0;
		end
	endtask

	// Drain outstanding results then report
	task automatic finish_test(input string name);
		idle_cycles(1);
		while (expect_q.size() != 0)
			@(posedge clk);
		$display("%s done, %0d failures", name, checks_failed - fails_at_start);
		fails_at_start = checks_failed;
	endtask

	// Valid comes out exactly three edges after issue
	valid_timing: assert property (@(posedge clk) disable iff (reset)
		result_valid_o == $past(issue_i.valid, 3))
	else
	begin
		$display("Fail result_valid_o expected %h got %h", !$sampled(result_valid_o),
			$sampled(result_valid_o));
		checks_failed++;
	end

	// Results must come back in issue order
	always @(posedge clk)
	begin
		if (reset)
			valid_run = 0;
		else if (result_valid_o)
		begin
			valid_run = valid_run + 1;
			if (valid_run > longest_run)
				longest_run = valid_run;
			if (expect_q.size() == 0)
			begin
				$display("Result came out with no operation outstanding");
				checks_failed++;
			end
			else
			begin
				expect_word = expect_q.pop_front();
				nan_match = expect_word[30:0] == F_NAN[30:0] && result_o[30:0] == F_NAN[30:0];
				result_value: assert (nan_match || result_o == expect_word)
					checks_passed++;
				else
				begin
					$display("Fail result_o expected %h got %h", expect_word, result_o);
					checks_failed++;
				end
			end
		end
		else
			valid_run = 0;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT)
		begin
			$display("Timeout, run went past %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	initial
	begin
		issue_i = '0;
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		idle_cycles(5);	// Nothing issued, valid must stay low
		for (int i = 0; i < 10; i++)
		begin
			if (GAP_PATTERN[i])
				issue_imul();
			else
				idle_cycles(1);
		end
		finish_test("reset_and_gaps");

		for (int i = 0; i < N_IMUL; i++)
			issue_imul();
		finish_test("imul_back_to_back");
		in_flight: assert (longest_run >= 3)
		else
		begin
			$display("IMUL burst never had three results in flight");
			checks_failed++;
		end

		for (int i = 0; i < N_ARITH - 4; i++)
			issue_float(fp_alu_pkg::op_e'(4'(2 + i % 3)), small_random(), small_random());
		for (int i = 0; i < 4; i++)
		begin
			int x;
			x = small_random();
			issue_float(fp_alu_pkg::OP_FSUB, x, x);	// Positive zero expected
		end
		finish_test("float_arith");

		for (int i = 0; i < N_CMP - 8; i++)
			issue_float(fp_alu_pkg::op_e'(4'(5 + i % 4)), small_random(), small_random());
		for (int i = 0; i < 8; i++)
		begin
			int x;
			x = small_random();
			issue_float(fp_alu_pkg::op_e'(4'(5 + i % 4)), x, x);
		end
		finish_test("float_compare");

		issue_op(fp_alu_pkg::OP_FADD, F_INF, to_float(5), F_INF);
		issue_op(fp_alu_pkg::OP_FSUB, to_float(5), F_INF, {1'b1, F_INF[30:0]});
		issue_op(fp_alu_pkg::OP_FSUB, F_INF, F_INF, F_NAN);	// inf - inf
		issue_op(fp_alu_pkg::OP_FMUL, F_INF, 32'h0, F_NAN);	// inf * 0
		issue_op(fp_alu_pkg::OP_FADD, F_NAN_IN, to_float(3), F_NAN);
		issue_op(fp_alu_pkg::OP_FMUL, to_float(2), F_NAN_IN, F_NAN);
		issue_op(fp_alu_pkg::OP_FSUB, F_NAN_IN, F_NAN_IN, F_NAN);
		issue_op(fp_alu_pkg::OP_FMUL, 32'h0, to_float(7), 32'h0);
		issue_op(fp_alu_pkg::OP_FMUL, 32'h0, to_float(-7), 32'h80000000);	// Signed zero
		issue_op(fp_alu_pkg::OP_FMUL, F_INF, to_float(-3), {1'b1, F_INF[30:0]});
		finish_test("special_values");

		for (int i = 0; i < N_MIX; i++)
		begin
			fp_alu_pkg::op_e op;
			op = fp_alu_pkg::op_e'(4'(1 + (next_random() >> 29)));	// Top bits, low ones cycle
			if (op == fp_alu_pkg::OP_IMUL)
				issue_imul();
			else
				issue_float(op, small_random(), small_random());
		end
		finish_test("mixed_stream");

		$display("Checks passed %0d, failed %0d", checks_passed, checks_failed);
		if (checks_failed == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: project.f
fp_alu_pkg.sv
fp_add_align.sv
fp_add_sum.sv
fp_mul_prepare.sv
integer_multiplier.sv
fp_normalize.sv
multi_cycle_alu.sv
tb_multi_cycle_alu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        = tb_multi_cycle_alu
RTL_TOP    = multi_cycle_alu
FILELIST   = project.f
OBJ_DIR    = obj_dir
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
LINT_FLAGS = --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Status comes from the pass search, the output is shown but not saved
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
